// File: event_logger_settings.svh
// event logger settings
// sizes, sample layout, register map and config bit positions
`ifndef EVENT_LOGGER_SETTINGS_SVH
`define EVENT_LOGGER_SETTINGS_SVH

// external inputs
`define LOG_GPIO_N        10    // number of external inputs that can trigger a message

// sample layout, in 16-bit words
`define LOG_TS_WORDS      4     // timestamp words at the start of each sample
`define LOG_MSG_WORDS     28    // message buffer depth
`define LOG_SAMPLE_WORDS  32    // total words per sample

// register map
`define LOG_PAGE_MSG      2     // addr[6:5] of the message buffer, 0x40..0x5f
`define LOG_ADDR_CONFIG   3     // config register

// config register, enable bit sits just above its field
`define LOG_CONF_MSG      13    // field in [12:8] = {invert, select[3:0]}
`define LOG_CONF_SYN      15    // field in [14] = sync channel enable
`define LOG_MSG_DISABLE   15    // select value that turns the message channel off

`endif

// File: event_logger_pkg.sv
// event logger types
// vector typedefs, bundled buses and the arbiter FSM encoding
`default_nettype none

package event_logger_pkg;

    typedef logic [15:0] log_word_t;   // one output word
    typedef logic [31:0] ts_sec_t;     // seconds
    typedef logic [19:0] ts_usec_t;    // microseconds
    typedef logic [6:0]  ctrl_addr_t;  // register address, page in [6:5]
    typedef logic [4:0]  msg_addr_t;   // message buffer index
    typedef logic        chan_id_t;    // 0 - message, 1 - external sync
    typedef logic [23:0] sample_cnt_t; // samples logged

    typedef struct packed {
        logic        we;    // single-cycle write
        logic        a;     // 1 - address write, 0 - data write
        logic [31:0] data;
    } cmd_bus_t;

    typedef struct packed {
        ts_sec_t  sec;
        ts_usec_t usec;
    } timestamp_t;

    typedef struct packed {
        logic [3:0] msg_sel;  // trigger input, 15 - disabled
        logic       msg_inv;  // invert trigger
        logic       syn_en;   // log received sync timestamps
    } log_cfg_t;

    typedef struct packed {
        logic      we;
        msg_addr_t addr;
        log_word_t data;
    } buf_wr_t;

    typedef enum logic [1:0] {
        ARB_IDLE,  // waiting for a channel with timestamp and data
        ARB_TS,    // emitting timestamp words
        ARB_DATA   // emitting channel data or zeros
    } arb_state_t;

endpackage

`default_nettype wire

// File: logger_cmd_regs.sv
// logger command registers
// address register with auto-increment on data writes, registered
// write decode, config register with per-field enables and the
// write port of the message buffer
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_settings.svh"

module logger_cmd_regs (
    input  wire                             xclk,
    input  wire                             config_rst,
    input  wire event_logger_pkg::cmd_bus_t i_cmd,
    output event_logger_pkg::log_cfg_t      o_cfg,
    output event_logger_pkg::buf_wr_t       o_buf_wr
);

    event_logger_pkg::ctrl_addr_t ctrl_addr;  // page in [6:5], index in [4:0]
    event_logger_pkg::msg_addr_t  buf_idx;    // buffer index of the pending write
    logic [31:0] cmd_data_r;                  // write data, valid one cycle after strobe
    logic        data_wr;                     // data (not address) write this cycle
    logic        addr_cfg;
    logic        addr_msg;
    logic        we_msg;                      // buffer write, index in range
    logic        we_cfg_msg;                  // message field enabled by bit 13
    logic        we_cfg_syn;                  // sync field enabled by bit 15

    assign data_wr  = i_cmd.we && !i_cmd.a;
    assign addr_cfg = (ctrl_addr == 7'(`LOG_ADDR_CONFIG));
    assign addr_msg = (ctrl_addr[6:5] == 2'(`LOG_PAGE_MSG));

    always_ff @(posedge xclk) begin
        if (i_cmd.we) begin
            cmd_data_r <= i_cmd.data;      // captured with the strobe
            buf_idx    <= ctrl_addr[4:0];  // index before the increment
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            we_msg     <= 1'b0;
            we_cfg_msg <= 1'b0;
            we_cfg_syn <= 1'b0;
        end else begin
            we_msg     <= data_wr && addr_msg && (ctrl_addr[4:0] < 5'(`LOG_MSG_WORDS));
            we_cfg_msg <= data_wr && addr_cfg && i_cmd.data[`LOG_CONF_MSG];
            we_cfg_syn <= data_wr && addr_cfg && i_cmd.data[`LOG_CONF_SYN];
        end
    end

    // address write sets all 7 bits, data writes step the low 5 and stop at 31
    always_ff @(posedge xclk) begin
        if (config_rst) begin
            ctrl_addr <= '0;
        end else if (i_cmd.we && i_cmd.a) begin
            ctrl_addr <= i_cmd.data[6:0];
        end else if (data_wr && (ctrl_addr[4:0] != 5'h1f)) begin
            ctrl_addr[4:0] <= ctrl_addr[4:0] + 5'd1;  // no rollover into next page
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_cfg <= '0;  // input 0, not inverted, sync off
        end else begin
            if (we_cfg_msg) begin
                {o_cfg.msg_inv, o_cfg.msg_sel} <= cmd_data_r[`LOG_CONF_MSG - 1 -: 5];
            end
            if (we_cfg_syn) begin
                o_cfg.syn_en <= cmd_data_r[`LOG_CONF_SYN - 1];
            end
        end
    end

    // index held from the strobe cycle
    assign o_buf_wr = '{we: we_msg, addr: buf_idx, data: cmd_data_r[15:0]};

endmodule

`default_nettype wire

// File: logger_msg_channel.sv
// message channel
// selected external input, synchronized and optionally inverted
// leading edge requests a timestamp, trailing edge releases the
// 28-word message stored by software
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_settings.svh"

module logger_msg_channel (
    input  wire                             xclk,
    input  wire                             config_rst,
    input  wire event_logger_pkg::log_cfg_t i_cfg,
    input  wire event_logger_pkg::buf_wr_t  i_buf_wr,
    input  wire [`LOG_GPIO_N-1:0]           i_ext_di,
    input  wire                             i_nxt,
    output logic                            o_ts_rq,
    output logic                            o_rdy,
    output event_logger_pkg::log_word_t     o_data
);

    event_logger_pkg::log_word_t msg_buf [`LOG_MSG_WORDS];
    event_logger_pkg::msg_addr_t rd_ptr;
    logic       msg_en;
    logic       trig_raw;   // selected input, async
    logic [1:0] trig_sync;  // two-flop synchronizer
    logic       trig;
    logic       trig_d;

    assign msg_en   = (i_cfg.msg_sel != 4'(`LOG_MSG_DISABLE));
    assign trig_raw = (i_cfg.msg_sel < 4'(`LOG_GPIO_N)) ? i_ext_di[i_cfg.msg_sel]
                                                        : i_ext_di[0];  // 10..14 read as 0
    assign trig     = msg_en && (trig_sync[1] ^ i_cfg.msg_inv);

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            trig_sync <= 2'b00;
            trig_d    <= 1'b0;
            o_ts_rq   <= 1'b0;
            o_rdy     <= 1'b0;
            rd_ptr    <= '0;
        end else begin
            trig_sync <= {trig_sync[0], trig_raw};
            trig_d    <= trig;
            o_ts_rq   <= trig && !trig_d;  // leading edge
            if (!trig && trig_d && !o_rdy) begin
                o_rdy  <= 1'b1;  // trailing edge, message complete
                rd_ptr <= '0;
            end else if (i_nxt && o_rdy) begin
                if (rd_ptr == 5'(`LOG_MSG_WORDS - 1)) begin
                    o_rdy <= 1'b0;  // last word read
                end else begin
                    rd_ptr <= rd_ptr + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (i_buf_wr.we) begin
            msg_buf[i_buf_wr.addr] <= i_buf_wr.data;  // index already range-checked
        end
    end

    assign o_data = msg_buf[rd_ptr];

endmodule

`default_nettype wire

// File: logger_exttime_channel.sv
// external sync channel
// holds the timestamp received over the sync line and serves it
// as four data words
`timescale 1ns/1ps
`default_nettype none

module logger_exttime_channel (
    input  wire                               xclk,
    input  wire                               config_rst,
    input  wire                               i_syn_en,
    input  wire                               i_ts_stb,
    input  wire event_logger_pkg::timestamp_t i_ts_rcv,
    input  wire                               i_nxt,
    output logic                              o_ts_rq,
    output logic                              o_rdy,
    output event_logger_pkg::log_word_t       o_data
);

    event_logger_pkg::timestamp_t ts_r;  // received time
    logic [1:0] word_idx;
    logic       take;                    // accept this strobe

    assign take = i_ts_stb && i_syn_en && !o_rdy;

    always_ff @(posedge xclk) begin
        if (take) begin
            ts_r <= i_ts_rcv;
        end
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_ts_rq  <= 1'b0;
            o_rdy    <= 1'b0;
            word_idx <= 2'd0;
        end else begin
            o_ts_rq <= take;  // same edge as rdy
            if (!i_syn_en) begin
                o_rdy    <= 1'b0;
                word_idx <= 2'd0;
            end else if (take) begin
                o_rdy    <= 1'b1;
                word_idx <= 2'd0;
            end else if (i_nxt && o_rdy) begin
                if (word_idx == 2'd3) begin
                    o_rdy <= 1'b0;  // rest of sample is zero fill
                end
                word_idx <= word_idx + 2'd1;
            end
        end
    end

    always_comb begin
        case (word_idx)
            2'd0:    o_data = ts_r.usec[15:0];
            2'd1:    o_data = {12'h000, ts_r.usec[19:16]};
            2'd2:    o_data = ts_r.sec[15:0];
            default: o_data = ts_r.sec[31:16];
        endcase
    end

endmodule

`default_nettype wire

// File: logger_timestamps.sv
// timestamp store
// latches local time for each channel on its request and holds it
// until the arbiter has emitted that channel's sample
`timescale 1ns/1ps
`default_nettype none

module logger_timestamps (
    input  wire                             xclk,
    input  wire                             config_rst,
    input  wire event_logger_pkg::ts_sec_t  i_sec,
    input  wire event_logger_pkg::ts_usec_t i_usec,
    input  wire [1:0]                       i_ts_rq,
    input  wire [1:0]                       i_done,
    input  wire event_logger_pkg::chan_id_t i_chan,
    input  wire [1:0]                       i_word,
    output logic [1:0]                      o_ts_valid,
    output event_logger_pkg::log_word_t     o_data
);

    event_logger_pkg::timestamp_t ts_r [2];
    event_logger_pkg::timestamp_t ts_sel;

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            o_ts_valid <= 2'b00;
        end else begin
            o_ts_valid <= (o_ts_valid | i_ts_rq) & ~i_done;  // done wins
        end
    end

    // a held timestamp is kept, later requests are dropped until done
    always_ff @(posedge xclk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (i_ts_rq[ch] && !o_ts_valid[ch]) begin
                ts_r[ch] <= '{sec: i_sec, usec: i_usec};
            end
        end
    end

    assign ts_sel = ts_r[i_chan];

    always_comb begin
        case (i_word)
            2'd0:    o_data = ts_sel.usec[15:0];
            2'd1:    o_data = {7'h00, i_chan, 4'h0, ts_sel.usec[19:16]};  // channel in bit 8
            2'd2:    o_data = ts_sel.sec[15:0];
            default: o_data = ts_sel.sec[31:16];
        endcase
    end

endmodule

`default_nettype wire

// File: logger_arbiter.sv
// sample arbiter
// picks a channel with timestamp and data (message first), steps
// through 4 timestamp and 28 data words, registers the output in two
// stages and counts logged samples
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_settings.svh"

module logger_arbiter (
    input  wire                              xclk,
    input  wire                              config_rst,
    input  wire [1:0]                        i_ts_valid,
    input  wire [1:0]                        i_rdy,
    input  wire event_logger_pkg::log_word_t i_ts_data,
    input  wire event_logger_pkg::log_word_t i_msg_data,
    input  wire event_logger_pkg::log_word_t i_ext_data,
    output event_logger_pkg::chan_id_t       o_chan,
    output logic [1:0]                       o_word,
    output logic [1:0]                       o_nxt,
    output logic [1:0]                       o_done,
    output event_logger_pkg::log_word_t      o_data,
    output logic                             o_data_stb,
    output event_logger_pkg::sample_cnt_t    o_sample_count
);

    event_logger_pkg::arb_state_t state;
    logic [4:0] word_cnt;                  // word of the sample being selected
    logic [1:0] eligible;
    logic       last_word;
    event_logger_pkg::log_word_t src_data; // stage 1, channel data
    event_logger_pkg::log_word_t ts_data_r;// stage 1, timestamp word
    logic       src_rdy;                   // stage 1, channel still has data
    logic       ts_en_r;                   // stage 1, timestamp word selected
    logic       dv_r;                      // stage 1 valid

    assign eligible  = i_ts_valid & i_rdy;
    assign last_word = (state == event_logger_pkg::ARB_DATA) &&
                       (word_cnt == 5'(`LOG_SAMPLE_WORDS - 1));
    assign o_word    = word_cnt[1:0];
    assign o_nxt     = (state == event_logger_pkg::ARB_DATA) ? (2'b01 << o_chan) : 2'b00;
    assign o_done    = last_word ? (2'b01 << o_chan) : 2'b00;

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            state          <= event_logger_pkg::ARB_IDLE;
            word_cnt       <= '0;
            o_chan         <= 1'b0;
            o_sample_count <= '0;
        end else begin
            case (state)
                event_logger_pkg::ARB_IDLE: begin
                    word_cnt <= '0;
                    if (eligible[0]) begin
                        o_chan <= 1'b0;  // message channel wins ties
                        state  <= event_logger_pkg::ARB_TS;
                    end else if (eligible[1]) begin
                        o_chan <= 1'b1;
                        state  <= event_logger_pkg::ARB_TS;
                    end
                end
                event_logger_pkg::ARB_TS: begin
                    word_cnt <= word_cnt + 5'd1;
                    if (word_cnt == 5'(`LOG_TS_WORDS - 1)) begin
                        state <= event_logger_pkg::ARB_DATA;
                    end
                end
                event_logger_pkg::ARB_DATA: begin
                    word_cnt <= word_cnt + 5'd1;
                    if (last_word) begin
                        state          <= event_logger_pkg::ARB_IDLE;
                        o_sample_count <= o_sample_count + 24'd1;
                    end
                end
                default: state <= event_logger_pkg::ARB_IDLE;
            endcase
        end
    end

    // stage 1 picks the channel, stage 2 picks timestamp, data or zero
    always_ff @(posedge xclk) begin
        ts_en_r   <= (state == event_logger_pkg::ARB_TS);
        ts_data_r <= i_ts_data;
        src_data  <= o_chan ? i_ext_data : i_msg_data;
        src_rdy   <= i_rdy[o_chan];
    end

    always_ff @(posedge xclk) begin
        if (config_rst) begin
            dv_r       <= 1'b0;
            o_data_stb <= 1'b0;
            o_data     <= '0;
        end else begin
            dv_r       <= (state != event_logger_pkg::ARB_IDLE);
            o_data_stb <= dv_r;
            if (!dv_r) begin
                o_data <= '0;  // idle bus reads zero
            end else if (ts_en_r) begin
                o_data <= ts_data_r;
            end else begin
                o_data <= src_rdy ? src_data : '0;  // zero fill after channel data
            end
        end
    end

endmodule

`default_nettype wire

// File: event_logger.sv
// event logger top
// command registers, message and external sync channels, shared
// timestamp store and the sample arbiter
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_settings.svh"

module event_logger (
    input  wire                               xclk,
    input  wire                               config_rst,
    input  wire event_logger_pkg::cmd_bus_t   i_cmd,
    input  wire event_logger_pkg::ts_sec_t    i_sec,
    input  wire event_logger_pkg::ts_usec_t   i_usec,
    input  wire [`LOG_GPIO_N-1:0]             i_ext_di,
    input  wire                               i_ts_stb,
    input  wire event_logger_pkg::timestamp_t i_ts_rcv,
    output wire event_logger_pkg::log_word_t  o_data,
    output wire                               o_data_stb,
    output wire event_logger_pkg::sample_cnt_t o_sample_count
);

    event_logger_pkg::log_cfg_t  cfg;
    event_logger_pkg::buf_wr_t   buf_wr;
    event_logger_pkg::log_word_t msg_data;
    event_logger_pkg::log_word_t ext_data;
    event_logger_pkg::log_word_t ts_data;
    event_logger_pkg::chan_id_t  chan;
    logic [1:0] word;      // timestamp word select
    logic [1:0] ts_rq;     // bit 0 message, bit 1 sync
    logic [1:0] ts_valid;
    logic [1:0] rdy;
    logic [1:0] nxt;
    logic [1:0] done;

    logger_cmd_regs logger_cmd_regs_inst (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cmd      (i_cmd),
        .o_cfg      (cfg),
        .o_buf_wr   (buf_wr)
    );

    logger_msg_channel logger_msg_channel_inst (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_cfg      (cfg),
        .i_buf_wr   (buf_wr),
        .i_ext_di   (i_ext_di),
        .i_nxt      (nxt[0]),
        .o_ts_rq    (ts_rq[0]),
        .o_rdy      (rdy[0]),
        .o_data     (msg_data)
    );

    logger_exttime_channel logger_exttime_channel_inst (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_syn_en   (cfg.syn_en),
        .i_ts_stb   (i_ts_stb),
        .i_ts_rcv   (i_ts_rcv),
        .i_nxt      (nxt[1]),
        .o_ts_rq    (ts_rq[1]),
        .o_rdy      (rdy[1]),
        .o_data     (ext_data)
    );

    logger_timestamps logger_timestamps_inst (
        .xclk       (xclk),
        .config_rst (config_rst),
        .i_sec      (i_sec),
        .i_usec     (i_usec),
        .i_ts_rq    (ts_rq),
        .i_done     (done),
        .i_chan     (chan),
        .i_word     (word),
        .o_ts_valid (ts_valid),
        .o_data     (ts_data)
    );

    logger_arbiter logger_arbiter_inst (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_ts_valid     (ts_valid),
        .i_rdy          (rdy),
        .i_ts_data      (ts_data),
        .i_msg_data     (msg_data),
        .i_ext_data     (ext_data),
        .o_chan         (chan),
        .o_word         (word),
        .o_nxt          (nxt),
        .o_done         (done),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

endmodule

`default_nettype wire

// File: event_logger_properties.sv
// event logger output properties
// strobe quiet in reset, count steps by one, idle bus reads zero
`timescale 1ns/1ps
`default_nettype none

module event_logger_properties (
    input wire                                xclk,
    input wire                                config_rst,
    input wire event_logger_pkg::log_word_t   o_data,
    input wire                                o_data_stb,
    input wire event_logger_pkg::sample_cnt_t o_sample_count
);

    a_stb_reset: assert property (@(posedge xclk) config_rst |=> !o_data_stb)
        else $error("o_data_stb high during reset");

    a_count_step: assert property (@(posedge xclk) disable iff (config_rst)
        !$past(config_rst) |-> (o_sample_count == $past(o_sample_count)) ||
                               (o_sample_count == $past(o_sample_count) + 24'd1))
        else $error("o_sample_count jumped");

    a_idle_zero: assert property (@(posedge xclk) disable iff (config_rst)
        !o_data_stb |-> (o_data == '0))
        else $error("o_data not zero without strobe");

endmodule

bind event_logger event_logger_properties event_logger_properties_inst (
    .xclk           (xclk),
    .config_rst     (config_rst),
    .o_data         (o_data),
    .o_data_stb     (o_data_stb),
    .o_sample_count (o_sample_count)
);

`default_nettype wire

// File: tb_event_logger.sv
// event logger testbench
// directed tests for reset, sync and message samples, inversion,
// disable and channel priority
`timescale 1ns/1ps
`default_nettype none
`include "event_logger_settings.svh"

module tb_event_logger;

    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 10 + 55 + 60 + 100 + 340 + 100;  // reset plus tests 1..5
    localparam logic [31:0] LOCAL_SEC  = 32'h1234_5678;           // held local time
    localparam logic [19:0] LOCAL_USEC = 20'h9_3c41;

    logic                            xclk;
    logic                            config_rst;
    event_logger_pkg::cmd_bus_t      i_cmd;
    event_logger_pkg::ts_sec_t       i_sec;
    event_logger_pkg::ts_usec_t      i_usec;
    logic [`LOG_GPIO_N-1:0]          i_ext_di;
    logic                            i_ts_stb;
    event_logger_pkg::timestamp_t    i_ts_rcv;
    event_logger_pkg::log_word_t     o_data;
    logic                            o_data_stb;
    event_logger_pkg::sample_cnt_t   o_sample_count;

    logic [31:0] lfsr_state;
    logic [15:0] exp_words [`LOG_SAMPLE_WORDS];  // expected sample
    logic [15:0] msg_words [`LOG_MSG_WORDS];     // what software stored
    int          fail_count;
    int          exp_count;                      // expected sample count

    event_logger event_logger_inst (
        .xclk           (xclk),
        .config_rst     (config_rst),
        .i_cmd          (i_cmd),
        .i_sec          (i_sec),
        .i_usec         (i_usec),
        .i_ext_di       (i_ext_di),
        .i_ts_stb       (i_ts_stb),
        .i_ts_rcv       (i_ts_rcv),
        .o_data         (o_data),
        .o_data_stb     (o_data_stb),
        .o_sample_count (o_sample_count)
    );

    initial begin
        xclk = 1'b0;
        forever #(CLK_PERIOD / 2) xclk = ~xclk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests completed");  // hung waiting on DUT
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge xclk);
        #1;  // drive just after the edge
    endtask

    task automatic cmd_write(input logic is_addr, input logic [31:0] data);
        i_cmd = '{we: 1'b1, a: is_addr, data: data};
        step(1);
        i_cmd = '{we: 1'b0, a: 1'b0, data: 32'h0};
    endtask

    task automatic write_config(input logic [31:0] data);
        cmd_write(1'b1, 32'(`LOG_ADDR_CONFIG));
        cmd_write(1'b0, data);
        step(4);  // lands two edges after the strobe
    endtask

    // local timestamp words, channel number in bit 8 of word 1
    task automatic expect_local_ts(input logic chan);
        exp_words[0] = LOCAL_USEC[15:0];
        exp_words[1] = {7'h00, chan, 4'h0, LOCAL_USEC[19:16]};
        exp_words[2] = LOCAL_SEC[15:0];
        exp_words[3] = LOCAL_SEC[31:16];
    endtask

    task automatic expect_msg();
        expect_local_ts(1'b0);
        for (int i = 0; i < `LOG_MSG_WORDS; i++) begin
            exp_words[`LOG_TS_WORDS + i] = msg_words[i];
        end
    endtask

    task automatic expect_sync(input event_logger_pkg::timestamp_t ts);
        expect_local_ts(1'b1);
        exp_words[4] = ts.usec[15:0];
        exp_words[5] = {12'h000, ts.usec[19:16]};
        exp_words[6] = ts.sec[15:0];
        exp_words[7] = ts.sec[31:16];
        for (int i = 8; i < `LOG_SAMPLE_WORDS; i++) begin
            exp_words[i] = 16'h0000;  // channel out of data
        end
    endtask

    // waits for the first strobe, then needs 32 strobed words in a row
    task automatic collect_sample();
        @(negedge xclk);
        while (o_data_stb !== 1'b1) begin
            @(negedge xclk);
        end
        for (int w = 0; w < `LOG_SAMPLE_WORDS; w++) begin
            check_value("o_data_stb", 32'(o_data_stb), 32'h1);
            check_value("o_data", 32'(o_data), 32'(exp_words[w]));
            @(negedge xclk);
        end
        step(1);  // back to drive phase
    endtask

    task automatic pulse_sync(output event_logger_pkg::timestamp_t ts);
        ts.sec   = lfsr_bits(32);
        ts.usec  = 20'(lfsr_bits(20));
        i_ts_rcv = ts;
        i_ts_stb = 1'b1;
        step(1);
        i_ts_stb = 1'b0;
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 50; i++) begin
            @(negedge xclk);
            check_value("o_data_stb", 32'(o_data_stb), 32'h0);
            check_value("o_sample_count", 32'(o_sample_count), 32'h0);
        end
        step(1);
    endtask

    task automatic test_sync_sample();
        event_logger_pkg::timestamp_t ts;
        write_config(32'h0000_c000);  // sync field enabled and set
        pulse_sync(ts);
        expect_sync(ts);
        collect_sample();
        exp_count++;
        check_value("o_sample_count", 32'(o_sample_count), 32'(exp_count));
    endtask

    task automatic test_msg_sample();
        cmd_write(1'b1, 32'h40);  // page 2, index 0
        for (int i = 0; i < `LOG_MSG_WORDS; i++) begin
            msg_words[i] = 16'(lfsr_bits(16));
            cmd_write(1'b0, {16'h0, msg_words[i]});  // address steps by itself
        end
        write_config(32'h0000_2300);  // input 3, not inverted
        i_ext_di[3] = 1'b1;
        step(10);
        i_ext_di[3] = 1'b0;
        expect_msg();
        collect_sample();
        exp_count++;
        check_value("o_sample_count", 32'(o_sample_count), 32'(exp_count));
    endtask

    task automatic test_invert_disable();
        int base;
        write_config(32'h0000_3300);  // inverted, low input is now active
        i_ext_di[3] = 1'b1;           // releases the pending event
        expect_msg();
        collect_sample();
        exp_count++;
        check_value("o_sample_count", 32'(o_sample_count), 32'(exp_count));
        i_ext_di[3] = 1'b0;           // falling input, leading edge when inverted
        step(6);
        i_ext_di[3] = 1'b1;
        collect_sample();
        exp_count++;
        check_value("o_sample_count", 32'(o_sample_count), 32'(exp_count));
        write_config(32'h0000_2f00);  // select 15, channel off
        base = exp_count;
        for (int i = 0; i < 200; i++) begin
            if (i % 7 == 0) begin
                i_ext_di = ~i_ext_di;
            end
            @(negedge xclk);
            check_value("o_data_stb", 32'(o_data_stb), 32'h0);
            check_value("o_sample_count", 32'(o_sample_count), 32'(base));
            step(1);
        end
        i_ext_di = '0;
        step(4);
        write_config(32'h0000_2300);  // back to input 3, not inverted
    endtask

    task automatic test_priority();
        event_logger_pkg::timestamp_t ts;
        i_ext_di[3] = 1'b1;  // leading edge takes the message timestamp
        step(6);
        i_ext_di[3] = 1'b0;
        step(1);
        pulse_sync(ts);      // both channels eligible on the same cycle
        expect_msg();
        collect_sample();
        expect_sync(ts);
        collect_sample();
        exp_count += 2;
        check_value("o_sample_count", 32'(o_sample_count), 32'(exp_count));
    endtask

    initial begin
        lfsr_state = 32'h694c_0cce;
        fail_count = 0;
        exp_count  = 0;
        config_rst = 1'b1;
        i_cmd      = '{we: 1'b0, a: 1'b0, data: 32'h0};
        i_sec      = LOCAL_SEC;
        i_usec     = LOCAL_USEC;
        i_ext_di   = '0;
        i_ts_stb   = 1'b0;
        i_ts_rcv   = '0;
        step(4);
        config_rst = 1'b0;
        test_reset_state();
        test_sync_sample();
        test_msg_sample();
        test_invert_disable();
        test_priority();
        step(4);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: event_logger.f
+incdir+.
event_logger_pkg.sv
logger_cmd_regs.sv
logger_msg_channel.sv
logger_exttime_channel.sv
logger_timestamps.sv
logger_arbiter.sv
event_logger.sv
event_logger_properties.sv
tb_event_logger.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the event logger testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_event_logger \
    -f event_logger.f -o sim_event_logger || { echo "build failed"; exit 1; }

./obj_dir/sim_event_logger > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"
